// File: project.f
src/cpuPkg.sv
src/fetchUnit.sv
src/instDecoder.sv
src/regFile.sv
src/hazardUnit.sv
src/executeUnit.sv
src/memAccess.sv
src/cpuCore.sv
sim/cpuCore_assert.sv
sim/cpuTb.sv

// File: run.sh
#!/bin/sh
# Build and run the cpuCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module cpuTb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VcpuTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
    exit 0
fi
exit 1

// File: sim/cpuTb.sv
module cpuTb;

    logic clk;
    logic reset;
    cpuPkg::wordT instAddr;
    cpuPkg::wordT instRdata;
    logic dataEn;
    cpuPkg::byteEnT dataWen;
    cpuPkg::wordT dataAddr;
    cpuPkg::wordT dataWdata;
    cpuPkg::wordT dataRdata;
    cpuPkg::dbgWbT debugWb;

    logic [31:0] lfsr;
    logic [31:0] imem [1024];
    logic [31:0] dmem [256];
    logic [31:0] mdlMem [256];
    int layout [1024];
    bit okTarget [1024];
    logic [31:0] expWrPc [$];
    logic [31:0] expWrIdx [$];
    logic [31:0] expWrVal [$];
    logic [31:0] expStAddr [$];
    logic [31:0] expStWen [$];
    logic [31:0] expStData [$];
    int writeCount;
    int errorCount;
    int resetCycles;
    int cycles;

    cpuCore u_dut (
        .clk(clk),
        .reset(reset),
        .instAddr(instAddr),
        .instRdata(instRdata),
        .dataEn(dataEn),
        .dataWen(dataWen),
        .dataAddr(dataAddr),
        .dataWdata(dataWdata),
        .dataRdata(dataRdata),
        .debugWb(debugWb)
    );

    always #2 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic nextBit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], nextBit()};
        end
        return v;
    endfunction

    // Mostly registers 1 to 4
    function automatic cpuPkg::regIdxT pickReg();
        cpuPkg::regIdxT r;
        if (randBits(2) != 0) begin
            r = 5'(randBits(2)) + 5'd1;
        end else begin
            r = 5'(randBits(5));
        end
        return r;
    endfunction

    function automatic logic [31:0] encR(input logic [4:0] rs, input logic [4:0] rt,
                                         input logic [4:0] rd, input logic [4:0] sh,
                                         input logic [5:0] fn);
        return {6'b000000, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encJ(input logic [5:0] op, input logic [25:0] t);
        return {op, t};
    endfunction

    // ALU or memory instruction that never writes r31
    function automatic logic [31:0] plainWord();
        logic [3:0] k;
        cpuPkg::regIdxT rs;
        cpuPkg::regIdxT rt;
        cpuPkg::regIdxT rd;
        cpuPkg::regIdxT dt;
        logic [15:0] imm;
        logic [31:0] w;
        k = 4'(randBits(4));
        rs = pickReg();
        rt = pickReg();
        rd = pickReg();
        imm = 16'(randBits(16));
        if (rd == 5'd31) rd = 5'd30;
        dt = (rt == 5'd31) ? 5'd30 : rt;
        case (k)
            4'd0: w = encR(rs, rt, rd, 5'd0, cpuPkg::fnAddu);
            4'd1: w = encR(rs, rt, rd, 5'd0, cpuPkg::fnSubu);
            4'd2: w = encR(rs, rt, rd, 5'd0, cpuPkg::fnAnd);
            4'd3: w = encR(rs, rt, rd, 5'd0, cpuPkg::fnOr);
            4'd4: w = encR(rs, rt, rd, 5'd0, cpuPkg::fnXor);
            4'd5: w = encR(rs, rt, rd, 5'd0, cpuPkg::fnSlt);
            4'd6: w = encR(rs, rt, rd, 5'd0, cpuPkg::fnSltu);
            4'd7: w = encR(5'd0, rt, rd, imm[4:0], cpuPkg::fnSll);
            4'd8: w = encI(cpuPkg::opAddiu, rs, dt, imm);
            4'd9: w = encI(cpuPkg::opAndi, rs, dt, imm);
            4'd10: w = encI(cpuPkg::opOri, rs, dt, imm);
            4'd11: w = encI(cpuPkg::opSlti, rs, dt, imm);
            4'd12: w = encI(cpuPkg::opLui, 5'd0, dt, imm);
            4'd13: w = encI(cpuPkg::opLw, 5'd0, dt, {6'b0, imm[7:0], 2'b00});
            4'd14: w = encI(imm[15] ? cpuPkg::opLb : cpuPkg::opLbu, 5'd0, dt,
                            {6'b0, imm[9:0]});
            default: w = imm[14] ? encI(cpuPkg::opSb, 5'd0, rt, {6'b0, imm[9:0]})
                                 : encI(cpuPkg::opSw, 5'd0, rt, {6'b0, imm[7:0], 2'b00});
        endcase
        return w;
    endfunction

    // Forward target outside any call block
    function automatic int pickTarget(input int i);
        int t;
        t = i + 2 + int'(randBits(4));
        if (t > 1022) t = 1022;
        while (!okTarget[t]) t++;
        return t;
    endfunction

    task automatic buildProgram();
        int i;
        int t;
        logic [2:0] c;
        for (int k = 0; k < 1024; k++) begin
            layout[k] = 0;
            okTarget[k] = 1'b1;
            imem[k] = plainWord();
        end
        for (int k = 0; k < 256; k++) begin
            dmem[k] = (32'(k) * 32'h9e3779b1) ^ 32'h5a5a_0f0f;
            mdlMem[k] = dmem[k];
        end
        i = 0;
        while (i < 1022) begin
            c = 3'(randBits(3));
            if ((c == 3'd0 || c == 3'd1) && i + 2 <= 1022) begin
                layout[i] = int'(c) + 1;
                i += 2;
            end else if (c == 3'd2 && i + 7 <= 1022) begin
                layout[i] = 3;
                for (int k = 1; k < 7; k++) okTarget[i + k] = 1'b0;
                i += 7;
            end else begin
                i += 1;
            end
        end
        for (int k = 0; k < 1022; k++) begin
            if (layout[k] == 1) begin
                t = pickTarget(k);
                imem[k] = encI(randBits(1) != 0 ? cpuPkg::opBeq : cpuPkg::opBne,
                               pickReg(), pickReg(), 16'(t - k - 1));
            end else if (layout[k] == 2) begin
                imem[k] = encJ(cpuPkg::opJ, 26'(pickTarget(k)));
            end else if (layout[k] == 3) begin
                // Call k+4, return to k+2, then leave through j to k+7
                imem[k] = encJ(cpuPkg::opJal, 26'(k + 4));
                imem[k + 2] = encJ(cpuPkg::opJ, 26'(k + 7));
                imem[k + 5] = encR(5'd31, 5'd0, 5'd0, 5'd0, cpuPkg::fnJr);
            end
        end
        imem[1022] = encJ(cpuPkg::opJ, 26'd0);
    endtask

    // Sequential ISA model with delay slots
    task automatic runModel();
        logic [31:0] r [32];
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] nnpc;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] sImm;
        logic [31:0] addr;
        logic [7:0] ld;
        logic [4:0] dst;
        logic wr;
        int steps;
        for (int k = 0; k < 32; k++) r[k] = '0;
        pc = 32'd0;
        npc = 32'd4;
        steps = 0;
        while (expWrPc.size() < 2100 && steps < 500000) begin
            inst = imem[pc[11:2]];
            a = r[inst[25:21]];
            b = r[inst[20:16]];
            sImm = {{16{inst[15]}}, inst[15:0]};
            addr = a + sImm;
            ld = mdlMem[addr[9:2]][8 * addr[1:0] +: 8];
            nnpc = npc + 32'd4;
            wr = 1'b1;
            dst = inst[20:16];
            res = '0;
            case (inst[31:26])
                cpuPkg::opSpecial: begin
                    dst = inst[15:11];
                    case (inst[5:0])
                        cpuPkg::fnAddu: res = a + b;
                        cpuPkg::fnSubu: res = a - b;
                        cpuPkg::fnAnd: res = a & b;
                        cpuPkg::fnOr: res = a | b;
                        cpuPkg::fnXor: res = a ^ b;
                        cpuPkg::fnSlt: res = {31'b0, $signed(a) < $signed(b)};
                        cpuPkg::fnSltu: res = {31'b0, a < b};
                        cpuPkg::fnSll: res = b << inst[10:6];
                        default: begin
                            wr = 1'b0;
                            if (inst[5:0] == cpuPkg::fnJr) nnpc = a;
                        end
                    endcase
                end
                cpuPkg::opAddiu: res = a + sImm;
                cpuPkg::opSlti: res = {31'b0, $signed(a) < $signed(sImm)};
                cpuPkg::opAndi: res = a & {16'h0, inst[15:0]};
                cpuPkg::opOri: res = a | {16'h0, inst[15:0]};
                cpuPkg::opLui: res = {inst[15:0], 16'h0};
                cpuPkg::opLw: res = mdlMem[addr[9:2]];
                cpuPkg::opLb: res = {{24{ld[7]}}, ld};
                cpuPkg::opLbu: res = {24'h0, ld};
                cpuPkg::opSw, cpuPkg::opSb: begin
                    wr = 1'b0;
                    expStAddr.push_back(addr);
                    if (inst[31:26] == cpuPkg::opSw) begin
                        expStWen.push_back(32'hf);
                        expStData.push_back(b);
                        mdlMem[addr[9:2]] = b;
                    end else begin
                        expStWen.push_back(32'd1 << addr[1:0]);
                        expStData.push_back({4{b[7:0]}});
                        mdlMem[addr[9:2]][8 * addr[1:0] +: 8] = b[7:0];
                    end
                end
                cpuPkg::opBeq, cpuPkg::opBne: begin
                    wr = 1'b0;
                    if ((a == b) == (inst[31:26] == cpuPkg::opBeq)) begin
                        nnpc = pc + 32'd4 + (sImm << 2);
                    end
                end
                default: begin
                    wr = (inst[31:26] == cpuPkg::opJal);
                    dst = 5'd31;
                    res = pc + 32'd8;
                    nnpc = {npc[31:28], inst[25:0], 2'b00};
                end
            endcase
            if (wr && dst != 5'd0) begin
                r[dst] = res;
                expWrPc.push_back(pc);
                expWrIdx.push_back(32'(dst));
                expWrVal.push_back(res);
            end
            pc = npc;
            npc = nnpc;
            steps++;
        end
    endtask

    task automatic checkEq(input string what, input logic [31:0] got,
                           input logic [31:0] exp);
        if (got !== exp) begin
            errorCount++;
            $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "aborted");
    endtask

    // SRAM models with one cycle read latency
    always @(posedge clk) begin
        instRdata <= imem[instAddr[11:2]];
        if (dataEn) begin
            dataRdata <= dmem[dataAddr[9:2]];
            for (int k = 0; k < 4; k++) begin
                if (dataWen[k]) dmem[dataAddr[9:2]][8 * k +: 8] <= dataWdata[8 * k +: 8];
            end
        end
    end

    // Compare writebacks and stores with the model streams
    always @(posedge clk) begin
        if (reset) begin
            resetCycles++;
            if (resetCycles > 1) begin
                checkEq("debug wen in reset", 32'(debugWb.wen), 32'd0);
                checkEq("dataEn in reset", 32'(dataEn), 32'd0);
            end
        end else begin
            if (debugWb.wen != 4'b0000) begin
                if (expWrPc.size() == 0) abortRun("DUT wrote more registers than the model");
                checkEq("writeback pc", debugWb.pc, expWrPc.pop_front());
                checkEq("writeback register", 32'(debugWb.wnum), expWrIdx.pop_front());
                checkEq("writeback data", debugWb.wdata, expWrVal.pop_front());
                writeCount++;
            end
            if (dataWen != 4'b0000) begin
                if (expStAddr.size() == 0) abortRun("DUT stored more than the model");
                checkEq("store address", dataAddr, expStAddr.pop_front());
                checkEq("store byte enable", 32'(dataWen), expStWen.pop_front());
                checkEq("store data", dataWdata, expStData.pop_front());
            end
        end
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        instRdata = '0;
        dataRdata = '0;
        lfsr = 32'hcf30a892;
        writeCount = 0;
        errorCount = 0;
        resetCycles = 0;
        buildProgram();
        runModel();
        if (expWrPc.size() < 2100) abortRun("model did not produce enough register writes");
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        checkEq("instAddr after reset", instAddr, cpuPkg::resetPc);
        for (cycles = 0; cycles < 40000 && writeCount < 2000; cycles++) begin
            @(negedge clk);
        end
        if (writeCount < 2000) begin
            $display("Timeout: only %0d register writes seen", writeCount);
            $display("RESULT: FAIL");
            $fatal(1, "timeout");
        end else if (errorCount == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("RESULT: FAIL");
            $fatal(1, "errors");
        end
    end

endmodule

// File: sim/cpuCore_assert.sv
module cpuCoreAssert (
    input logic clk,
    input logic reset,
    input logic dataEn,
    input cpuPkg::byteEnT dataWen,
    input cpuPkg::wordT instAddr,
    input cpuPkg::dbgWbT debugWb
);

    // A write lane needs an access
    assert property (@(posedge clk) disable iff (reset) (dataWen != 4'b0000) |-> dataEn)
        else $error("dataWen is set without dataEn");

    assert property (@(posedge clk) disable iff (reset)
        (debugWb.wen == 4'b0000) || (debugWb.wen == 4'b1111))
        else $error("debug write enable is partial");

    assert property (@(posedge clk) disable iff (reset) instAddr[1:0] == 2'b00)
        else $error("instAddr is not word aligned");

    // Skips the first reset edge, when the stage flags are still unset
    assert property (@(posedge clk) (reset && $past(reset)) |->
        (!dataEn && debugWb.wen == 4'b0000))
        else $error("dataEn or debug write enable active in reset");

endmodule

bind cpuCore cpuCoreAssert uAssert (
    .clk(clk),
    .reset(reset),
    .dataEn(dataEn),
    .dataWen(dataWen),
    .instAddr(instAddr),
    .debugWb(debugWb)
);

// File: src/cpuCore.sv
module cpuCore (
    input logic clk,
    input logic reset,
    output cpuPkg::wordT instAddr,
    input cpuPkg::wordT instRdata,
    output logic dataEn,
    output cpuPkg::byteEnT dataWen,
    output cpuPkg::wordT dataAddr,
    output cpuPkg::wordT dataWdata,
    input cpuPkg::wordT dataRdata,
    output cpuPkg::dbgWbT debugWb
);

    // D stage
    cpuPkg::wordT dPc;
    cpuPkg::wordT dInst;
    cpuPkg::wordT dInstSaved;
    logic dBubble;
    logic dHold;
    cpuPkg::ctrlT dCtrl;
    cpuPkg::wordT regA;
    cpuPkg::wordT regB;
    cpuPkg::wordT valA;
    cpuPkg::wordT valB;
    logic hazStall;
    logic stall;
    logic taken;
    logic redirect;
    cpuPkg::wordT target;

    // E, M and W stages
    cpuPkg::ctrlT eCtrl;
    cpuPkg::wordT ePc;
    cpuPkg::wordT eA;
    cpuPkg::wordT eB;
    cpuPkg::wordT eResult;
    logic eBubble;
    cpuPkg::ctrlT mCtrl;
    cpuPkg::wordT mPc;
    cpuPkg::wordT mResult;
    cpuPkg::wordT mStoreData;
    logic mBubble;
    cpuPkg::ctrlT wCtrl;
    cpuPkg::wordT wPc;
    cpuPkg::wordT wResult;
    cpuPkg::wordT loadValue;
    cpuPkg::wordT wbValue;
    cpuPkg::regIdxT wDest;
    logic wBubble;

    cpuPkg::fwdSrcT fwdE;
    cpuPkg::fwdSrcT fwdM;
    cpuPkg::fwdSrcT fwdW;

    fetchUnit uFetch (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .redirect(redirect),
        .redirectAddr(target),
        .instAddr(instAddr)
    );

    // The SRAM moves on during a stall, so D keeps its own copy of the word
    assign dInst = dHold ? dInstSaved : instRdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            dBubble <= 1'b1;
            dHold <= 1'b0;
        end else begin
            dHold <= stall;
            if (!stall) begin
                dBubble <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        dInstSaved <= dInst;
        if (!stall) begin
            dPc <= instAddr;
        end
    end

    instDecoder uDecoder (
        .inst(dInst),
        .ctrl(dCtrl)
    );

    regFile uRegs (
        .clk(clk),
        .reset(reset),
        .readIdxA(dCtrl.rs),
        .readIdxB(dCtrl.rt),
        .readA(regA),
        .readB(regB),
        .writeIdx(wDest),
        .writeData(wbValue)
    );

    hazardUnit uHazard (
        .ctrl(dCtrl),
        .regA(regA),
        .regB(regB),
        .fwdE(fwdE),
        .fwdM(fwdM),
        .fwdW(fwdW),
        .valA(valA),
        .valB(valB),
        .stall(hazStall)
    );

    assign stall = hazStall && !dBubble;

    // Branch resolution on forwarded operands
    always_comb begin
        taken = 1'b0;
        target = dPc + 32'd4 + {dCtrl.imm[29:0], 2'b00};
        case (dCtrl.jumpKind)
            cpuPkg::jumpBeq: taken = (valA == valB);
            cpuPkg::jumpBne: taken = (valA != valB);
            cpuPkg::jumpImm: begin
                taken = 1'b1;
                target = {dPc[31:28], dCtrl.jumpField, 2'b00};
            end
            cpuPkg::jumpReg: begin
                taken = 1'b1;
                target = valA;
            end
            default: taken = 1'b0;
        endcase
    end

    assign redirect = taken && !dBubble && !stall;

    // Only jal has its value ready in E
    assign fwdE.valid = (eCtrl.wbSrc == cpuPkg::wbLink);
    assign fwdE.idx = eBubble ? '0 : eCtrl.dest;
    assign fwdE.value = eResult;

    assign fwdM.valid = (mCtrl.wbSrc == cpuPkg::wbAlu) || (mCtrl.wbSrc == cpuPkg::wbLink);
    assign fwdM.idx = mBubble ? '0 : mCtrl.dest;
    assign fwdM.value = mResult;

    assign fwdW.valid = 1'b1;
    assign fwdW.idx = wDest;
    assign fwdW.value = wbValue;

    always_ff @(posedge clk) begin
        if (reset) begin
            eBubble <= 1'b1;
            mBubble <= 1'b1;
            wBubble <= 1'b1;
        end else begin
            eBubble <= dBubble || stall;
            mBubble <= eBubble;
            wBubble <= mBubble;
        end
    end

    always_ff @(posedge clk) begin
        eCtrl <= dCtrl;
        ePc <= dPc;
        eA <= valA;
        eB <= valB;
        mCtrl <= eCtrl;
        mPc <= ePc;
        mResult <= eResult;
        mStoreData <= eB;
        wCtrl <= mCtrl;
        wPc <= mPc;
        wResult <= mResult;
    end

    executeUnit uExecute (
        .ctrl(eCtrl),
        .opA(eA),
        .opB(eB),
        .pc(ePc),
        .result(eResult)
    );

    memAccess uMem (
        .storeWidth(mCtrl.memWidth),
        .storeEn(!mBubble && mCtrl.isStore),
        .addrM(mResult),
        .storeData(mStoreData),
        .wen(dataWen),
        .wdata(dataWdata),
        .loadWidth(wCtrl.memWidth),
        .loadSigned(wCtrl.loadSigned),
        .addrW(wResult),
        .rdata(dataRdata),
        .loadValue(loadValue)
    );

    assign dataEn = !mBubble && (mCtrl.isLoad || mCtrl.isStore);
    assign dataAddr = mResult;

    // Writeback
    assign wDest = wBubble ? '0 : wCtrl.dest;
    assign wbValue = (wCtrl.wbSrc == cpuPkg::wbMem) ? loadValue : wResult;

    assign debugWb.pc = wPc;
    assign debugWb.wen = (wDest != '0 && wCtrl.wbSrc != cpuPkg::wbNone) ? 4'b1111 : 4'b0000;
    assign debugWb.wnum = wDest;
    assign debugWb.wdata = wbValue;

endmodule

// File: src/memAccess.sv
module memAccess (
    input cpuPkg::memWidthT storeWidth,
    input logic storeEn,
    input cpuPkg::wordT addrM,
    input cpuPkg::wordT storeData,
    output cpuPkg::byteEnT wen,
    output cpuPkg::wordT wdata,
    input cpuPkg::memWidthT loadWidth,
    input logic loadSigned,
    input cpuPkg::wordT addrW,
    input cpuPkg::wordT rdata,
    output cpuPkg::wordT loadValue
);

    logic [7:0] loadByte;

    // Store side, M stage
    always_comb begin
        if (storeWidth == cpuPkg::memByte) begin
            wdata = {4{storeData[7:0]}};
            wen = storeEn ? (cpuPkg::byteEnT'(1) << addrM[1:0]) : '0;
        end else begin
            wdata = storeData;
            wen = storeEn ? 4'b1111 : '0;
        end
    end

    // Load side, W stage
    always_comb begin
        case (addrW[1:0])
            2'd1: loadByte = rdata[15:8];
            2'd2: loadByte = rdata[23:16];
            2'd3: loadByte = rdata[31:24];
            default: loadByte = rdata[7:0];
        endcase
        if (loadWidth == cpuPkg::memWord) begin
            loadValue = rdata;
        end else if (loadSigned) begin
            loadValue = {{24{loadByte[7]}}, loadByte};
        end else begin
            loadValue = {24'h000000, loadByte};
        end
    end

endmodule

// File: src/executeUnit.sv
module executeUnit (
    input cpuPkg::ctrlT ctrl,
    input cpuPkg::wordT opA,
    input cpuPkg::wordT opB,
    input cpuPkg::wordT pc,
    output cpuPkg::wordT result
);

    cpuPkg::wordT aluB;
    logic [4:0] shamt;

    assign aluB = ctrl.aluSrcImm ? ctrl.imm : opB;
    // shamt sits in bits 10:6 of the instruction
    assign shamt = ctrl.imm[10:6];

    always_comb begin
        if (ctrl.wbSrc == cpuPkg::wbLink) begin
            // Return past the delay slot
            result = pc + 32'd8;
        end else begin
            case (ctrl.aluOp)
                cpuPkg::aluSub: result = opA - aluB;
                cpuPkg::aluAnd: result = opA & aluB;
                cpuPkg::aluOr: result = opA | aluB;
                cpuPkg::aluXor: result = opA ^ aluB;
                cpuPkg::aluSlt: result = {31'b0, $signed(opA) < $signed(aluB)};
                cpuPkg::aluSltu: result = {31'b0, opA < aluB};
                cpuPkg::aluSll: result = aluB << shamt;
                cpuPkg::aluLui: result = {aluB[15:0], 16'h0000};
                default: result = opA + aluB;
            endcase
        end
    end

endmodule

// File: src/hazardUnit.sv
module hazardUnit (
    input cpuPkg::ctrlT ctrl,
    input cpuPkg::wordT regA,
    input cpuPkg::wordT regB,
    input cpuPkg::fwdSrcT fwdE,
    input cpuPkg::fwdSrcT fwdM,
    input cpuPkg::fwdSrcT fwdW,
    output cpuPkg::wordT valA,
    output cpuPkg::wordT valB,
    output logic stall
);

    logic waitA;
    logic waitB;

    // Youngest matching producer wins; a match without a value means wait
    function automatic void resolve(
        input cpuPkg::regIdxT idx,
        input logic used,
        input cpuPkg::wordT regVal,
        output cpuPkg::wordT val,
        output logic waitOut
    );
        val = regVal;
        waitOut = 1'b0;
        if (used && idx != '0) begin
            if (fwdE.idx == idx) begin
                val = fwdE.value;
                waitOut = !fwdE.valid;
            end else if (fwdM.idx == idx) begin
                val = fwdM.value;
                waitOut = !fwdM.valid;
            end else if (fwdW.idx == idx) begin
                val = fwdW.value;
                waitOut = !fwdW.valid;
            end
        end
    endfunction

    always_comb begin
        resolve(ctrl.rs, ctrl.useRs, regA, valA, waitA);
        resolve(ctrl.rt, ctrl.useRt, regB, valB, waitB);
    end

    assign stall = waitA || waitB;

endmodule

// File: src/regFile.sv
module regFile (
    input logic clk,
    input logic reset,
    input cpuPkg::regIdxT readIdxA,
    input cpuPkg::regIdxT readIdxB,
    output cpuPkg::wordT readA,
    output cpuPkg::wordT readB,
    input cpuPkg::regIdxT writeIdx,
    input cpuPkg::wordT writeData
);

    // $zero has no storage
    cpuPkg::wordT regs [1:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeIdx != '0) begin
            regs[writeIdx] <= writeData;
        end
    end

    assign readA = (readIdxA == '0) ? '0 : regs[readIdxA];
    assign readB = (readIdxB == '0) ? '0 : regs[readIdxB];

endmodule

// File: src/instDecoder.sv
module instDecoder (
    input cpuPkg::wordT inst,
    output cpuPkg::ctrlT ctrl
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic rType;
    cpuPkg::wordT immSign;
    cpuPkg::wordT immZero;

    assign opcode = inst[31:26];
    assign funct = inst[5:0];
    assign immSign = {{16{inst[15]}}, inst[15:0]};
    assign immZero = {16'h0000, inst[15:0]};

    always_comb begin
        ctrl = '0;
        rType = 1'b0;
        ctrl.rs = inst[25:21];
        ctrl.rt = inst[20:16];
        ctrl.imm = immSign;
        ctrl.jumpField = inst[25:0];
        case (opcode)
            cpuPkg::opSpecial: begin
                rType = 1'b1;
                case (funct)
                    cpuPkg::fnAddu: ctrl.aluOp = cpuPkg::aluAdd;
                    cpuPkg::fnSubu: ctrl.aluOp = cpuPkg::aluSub;
                    cpuPkg::fnAnd: ctrl.aluOp = cpuPkg::aluAnd;
                    cpuPkg::fnOr: ctrl.aluOp = cpuPkg::aluOr;
                    cpuPkg::fnXor: ctrl.aluOp = cpuPkg::aluXor;
                    cpuPkg::fnSlt: ctrl.aluOp = cpuPkg::aluSlt;
                    cpuPkg::fnSltu: ctrl.aluOp = cpuPkg::aluSltu;
                    cpuPkg::fnSll: ctrl.aluOp = cpuPkg::aluSll;
                    cpuPkg::fnJr: begin
                        rType = 1'b0;
                        ctrl.useRs = 1'b1;
                        ctrl.jumpKind = cpuPkg::jumpReg;
                    end
                    default: rType = 1'b0;
                endcase
                if (rType) begin
                    // sll shifts rt only
                    ctrl.useRs = (funct != cpuPkg::fnSll);
                    ctrl.useRt = 1'b1;
                    ctrl.dest = inst[15:11];
                    ctrl.wbSrc = cpuPkg::wbAlu;
                end
            end
            cpuPkg::opAddiu, cpuPkg::opSlti, cpuPkg::opAndi, cpuPkg::opOri,
            cpuPkg::opLui: begin
                ctrl.useRs = (opcode != cpuPkg::opLui);
                ctrl.dest = inst[20:16];
                ctrl.aluSrcImm = 1'b1;
                ctrl.wbSrc = cpuPkg::wbAlu;
                case (opcode)
                    cpuPkg::opSlti: ctrl.aluOp = cpuPkg::aluSlt;
                    cpuPkg::opAndi: ctrl.aluOp = cpuPkg::aluAnd;
                    cpuPkg::opOri: ctrl.aluOp = cpuPkg::aluOr;
                    cpuPkg::opLui: ctrl.aluOp = cpuPkg::aluLui;
                    default: ctrl.aluOp = cpuPkg::aluAdd;
                endcase
                // Logical immediates are zero extended
                if (opcode == cpuPkg::opAndi || opcode == cpuPkg::opOri ||
                    opcode == cpuPkg::opLui) begin
                    ctrl.imm = immZero;
                end
            end
            cpuPkg::opLw, cpuPkg::opLb, cpuPkg::opLbu: begin
                ctrl.useRs = 1'b1;
                ctrl.dest = inst[20:16];
                ctrl.aluSrcImm = 1'b1;
                ctrl.wbSrc = cpuPkg::wbMem;
                ctrl.isLoad = 1'b1;
                ctrl.loadSigned = (opcode == cpuPkg::opLb);
                ctrl.memWidth = (opcode == cpuPkg::opLw) ? cpuPkg::memWord : cpuPkg::memByte;
            end
            cpuPkg::opSw, cpuPkg::opSb: begin
                ctrl.useRs = 1'b1;
                ctrl.useRt = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.isStore = 1'b1;
                ctrl.memWidth = (opcode == cpuPkg::opSw) ? cpuPkg::memWord : cpuPkg::memByte;
            end
            cpuPkg::opBeq, cpuPkg::opBne: begin
                ctrl.useRs = 1'b1;
                ctrl.useRt = 1'b1;
                ctrl.jumpKind = (opcode == cpuPkg::opBeq) ? cpuPkg::jumpBeq : cpuPkg::jumpBne;
            end
            cpuPkg::opJ: ctrl.jumpKind = cpuPkg::jumpImm;
            cpuPkg::opJal: begin
                ctrl.jumpKind = cpuPkg::jumpImm;
                ctrl.dest = cpuPkg::linkReg;
                ctrl.wbSrc = cpuPkg::wbLink;
            end
            default: ctrl.jumpKind = cpuPkg::jumpNone;
        endcase
    end

endmodule

// File: src/fetchUnit.sv
module fetchUnit (
    input logic clk,
    input logic reset,
    input logic stall,
    input logic redirect,
    input cpuPkg::wordT redirectAddr,
    output cpuPkg::wordT instAddr
);

    // Address presented to the instruction SRAM
    cpuPkg::wordT fetchPc;

    // The delay slot is already on its way when redirect arrives,
    // so the target is the next address presented after it.
    // Redirect is only raised by an unstalled D.
    always_ff @(posedge clk) begin
        if (reset) begin
            fetchPc <= cpuPkg::resetPc;
        end else if (redirect) begin
            fetchPc <= redirectAddr;
        end else if (!stall) begin
            fetchPc <= fetchPc + 32'd4;
        end
    end

    assign instAddr = fetchPc;

endmodule

// File: src/cpuPkg.sv
package cpuPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0] regIdxT;
    typedef logic [3:0] byteEnT;

    localparam wordT resetPc = 32'h0000_0000;
    localparam regIdxT linkReg = 5'd31;

    // Major opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJ = 6'h02;
    localparam logic [5:0] opJal = 6'h03;
    localparam logic [5:0] opBeq = 6'h04;
    localparam logic [5:0] opBne = 6'h05;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opSlti = 6'h0a;
    localparam logic [5:0] opAndi = 6'h0c;
    localparam logic [5:0] opOri = 6'h0d;
    localparam logic [5:0] opLui = 6'h0f;
    localparam logic [5:0] opLb = 6'h20;
    localparam logic [5:0] opLw = 6'h23;
    localparam logic [5:0] opLbu = 6'h24;
    localparam logic [5:0] opSb = 6'h28;
    localparam logic [5:0] opSw = 6'h2b;

    // SPECIAL funct codes
    localparam logic [5:0] fnSll = 6'h00;
    localparam logic [5:0] fnJr = 6'h08;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr = 6'h25;
    localparam logic [5:0] fnXor = 6'h26;
    localparam logic [5:0] fnSlt = 6'h2a;
    localparam logic [5:0] fnSltu = 6'h2b;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSltu, aluSll, aluLui
    } aluOpT;

    typedef enum logic [1:0] {wbNone, wbAlu, wbMem, wbLink} wbSrcT;

    typedef enum logic {memWord, memByte} memWidthT;

    typedef enum logic [2:0] {jumpNone, jumpBeq, jumpBne, jumpImm, jumpReg} jumpKindT;

    // An all-zero ctrlT is a no-op
    typedef struct packed {
        regIdxT rs;
        regIdxT rt;
        logic useRs;
        logic useRt;
        regIdxT dest;
        aluOpT aluOp;
        logic aluSrcImm;
        wordT imm;
        wbSrcT wbSrc;
        memWidthT memWidth;
        logic isLoad;
        logic isStore;
        logic loadSigned;
        jumpKindT jumpKind;
        logic [25:0] jumpField;
    } ctrlT;

    typedef struct packed {
        logic valid;
        regIdxT idx;
        wordT value;
    } fwdSrcT;

    typedef struct packed {
        wordT pc;
        byteEnT wen;
        regIdxT wnum;
        wordT wdata;
    } dbgWbT;

endpackage
